// File: include/afifo_settings.svh
`ifndef AFIFO_SETTINGS_SVH
`define AFIFO_SETTINGS_SVH

// byte-wide write port
`define AFIFO_W_DATA_W 8

// word-wide read port
`define AFIFO_R_DATA_W 32

// narrow side address, 256 byte slots
`define AFIFO_ADDR_W 8
// log2 of read/write width ratio
`define AFIFO_LANE_W 2

`endif

// File: hw/afifo_data_pkg.sv
package afifo_data_pkg;

`include "afifo_settings.svh"

   // one byte as it enters the write port
   typedef logic [`AFIFO_W_DATA_W-1:0] w_data_t;

   // one word as it leaves the read port, lane 0 holds the oldest byte
   typedef logic [`AFIFO_R_DATA_W-1:0] r_data_t;

endpackage

// File: hw/afifo_ptr_pkg.sv
package afifo_ptr_pkg;

`include "afifo_settings.svh"

   // write pointer and write level, counted in bytes
   typedef logic [`AFIFO_ADDR_W-1:0] w_ptr_t;

   // read pointer and read level, counted in words
   typedef logic [`AFIFO_ADDR_W-`AFIFO_LANE_W-1:0] r_ptr_t;

   function automatic w_ptr_t gray2bin_w(input w_ptr_t gray);
      w_ptr_t bin;
      int i;
      bin[$bits(w_ptr_t)-1] = gray[$bits(w_ptr_t)-1];
      // each binary bit folds in all gray bits above it
      for (i = $bits(w_ptr_t) - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i+1];
      end
      return bin;
   endfunction

   function automatic r_ptr_t gray2bin_r(input r_ptr_t gray);
      r_ptr_t bin;
      int i;
      bin[$bits(r_ptr_t)-1] = gray[$bits(r_ptr_t)-1];
      for (i = $bits(r_ptr_t) - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i+1];
      end
      return bin;
   endfunction

endpackage

// File: hw/afifo_gray_counter.sv
`timescale 1ns/1ps

module afifo_gray_counter #(
   parameter int WIDTH = 8
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [WIDTH-1:0] gray
);

   // binary runs one step ahead of the gray register
   logic [WIDTH-1:0] bin;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin  <= WIDTH'(1);
         gray <= '0;
      end else if (en) begin
         bin  <= bin + 1'b1;
         // gray code of the step count reached by this enable
         gray <= bin ^ (bin >> 1);
      end
   end

endmodule

// File: hw/afifo_wr_ctrl.sv
`timescale 1ns/1ps

`include "afifo_settings.svh"

module afifo_wr_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  write_en,
   input  afifo_ptr_pkg::r_ptr_t rd_gray,
   output afifo_ptr_pkg::w_ptr_t wr_gray,
   output afifo_ptr_pkg::w_ptr_t wr_addr,
   output logic                  wr_accept,
   output afifo_ptr_pkg::w_ptr_t level_w,
   output logic                  full
);

   import afifo_ptr_pkg::*;

   r_ptr_t rd_gray_meta;
   r_ptr_t rd_gray_sync;
   w_ptr_t rd_ptr_wide;

   // read pointer into the write clock, two flops
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end else begin
         rd_gray_meta <= rd_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   // writes into a full fifo are dropped
   assign wr_accept = write_en & ~full;

   afifo_gray_counter #(
      .WIDTH($bits(w_ptr_t))
   ) u_wr_ptr (
      .clk  (clk),
      .rst  (rst),
      .en   (wr_accept),
      .gray (wr_gray)
   );

   assign wr_addr = gray2bin_w(wr_gray);

   // word pointer scaled up to byte units
   assign rd_ptr_wide = {gray2bin_r(rd_gray_sync), {`AFIFO_LANE_W{1'b0}}};

   assign level_w = wr_addr - rd_ptr_wide;

   // one slot kept free so full and empty stay distinct
   assign full = (level_w == {`AFIFO_ADDR_W{1'b1}});

endmodule

// File: hw/afifo_rd_ctrl.sv
`timescale 1ns/1ps

`include "afifo_settings.svh"

module afifo_rd_ctrl (
   input  logic                  rd_clk,
   input  logic                  rst,
   input  logic                  read_en,
   input  afifo_ptr_pkg::w_ptr_t wr_gray,
   output afifo_ptr_pkg::r_ptr_t rd_gray,
   output afifo_ptr_pkg::r_ptr_t rd_addr,
   output logic                  rd_accept,
   output afifo_ptr_pkg::r_ptr_t level_r,
   output logic                  empty
);

   import afifo_ptr_pkg::*;

   w_ptr_t wr_gray_meta;
   w_ptr_t wr_gray_sync;
   w_ptr_t wr_ptr_bin;
   r_ptr_t wr_ptr_narrow;

   // write pointer into the read clock
   always_ff @(posedge rd_clk or posedge rst) begin
      if (rst) begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end else begin
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   // reads from an empty fifo are dropped
   assign rd_accept = read_en & ~empty;

   afifo_gray_counter #(
      .WIDTH($bits(r_ptr_t))
   ) u_rd_ptr (
      .clk  (rd_clk),
      .rst  (rst),
      .en   (rd_accept),
      .gray (rd_gray)
   );

   assign rd_addr = gray2bin_r(rd_gray);

   // byte count down to whole words, a partial word stays hidden
   assign wr_ptr_bin    = gray2bin_w(wr_gray_sync);
   assign wr_ptr_narrow = wr_ptr_bin[`AFIFO_ADDR_W-1:`AFIFO_LANE_W];

   assign level_r = wr_ptr_narrow - rd_addr;

   assign empty = (level_r == '0);

endmodule

// File: hw/afifo_asym_mem.sv
`timescale 1ns/1ps

`include "afifo_settings.svh"

module afifo_asym_mem (
   input  logic                   clk,
   input  logic                   wr_accept,
   input  afifo_ptr_pkg::w_ptr_t  wr_addr,
   input  afifo_data_pkg::w_data_t data_in,
   input  logic                   rd_clk,
   input  logic                   rst,
   input  logic                   rd_accept,
   input  afifo_ptr_pkg::r_ptr_t  rd_addr,
   output afifo_data_pkg::r_data_t data_out
);

   import afifo_ptr_pkg::*;
   import afifo_data_pkg::*;

   localparam int WORDS = 1 << (`AFIFO_ADDR_W - `AFIFO_LANE_W);
   localparam int LANES = 1 << `AFIFO_LANE_W;

   logic [`AFIFO_LANE_W-1:0] wr_lane;
   r_ptr_t                   wr_word;
   r_data_t                  rd_word;

   // low address bits pick the lane, upper bits the word
   assign wr_lane = wr_addr[`AFIFO_LANE_W-1:0];
   assign wr_word = wr_addr[`AFIFO_ADDR_W-1:`AFIFO_LANE_W];

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      w_data_t lane_mem [WORDS];

      always_ff @(posedge clk) begin
         if (wr_accept && (wr_lane == `AFIFO_LANE_W'(l))) begin
            lane_mem[wr_word] <= data_in;
         end
      end

      // lane 0 lands in the least significant byte
      assign rd_word[l*`AFIFO_W_DATA_W +: `AFIFO_W_DATA_W] = lane_mem[rd_addr];
   end

   // registered word output, held when no read is accepted
   always_ff @(posedge rd_clk or posedge rst) begin
      if (rst) begin
         data_out <= '0;
      end else if (rd_accept) begin
         data_out <= rd_word;
      end
   end

endmodule

// File: hw/afifo_asym_top.sv
`timescale 1ns/1ps

module afifo_asym_top (
   input  logic                    clk,
   input  logic                    rd_clk,
   input  logic                    rst,

   // write port, clk domain
   input  logic                    write_en,
   input  afifo_data_pkg::w_data_t data_in,
   output logic                    full,
   output afifo_ptr_pkg::w_ptr_t   level_w,

   // read port, rd_clk domain
   input  logic                    read_en,
   output afifo_data_pkg::r_data_t data_out,
   output logic                    empty,
   output afifo_ptr_pkg::r_ptr_t   level_r
);

   import afifo_ptr_pkg::*;

   // gray pointers crossing between domains
   w_ptr_t wr_gray;
   r_ptr_t rd_gray;

   // binary addresses into the memory
   w_ptr_t wr_addr;
   r_ptr_t rd_addr;

   logic   wr_accept;
   logic   rd_accept;

   afifo_wr_ctrl u_wr_ctrl (
      .clk       (clk),
      .rst       (rst),
      .write_en  (write_en),
      .rd_gray   (rd_gray),
      .wr_gray   (wr_gray),
      .wr_addr   (wr_addr),
      .wr_accept (wr_accept),
      .level_w   (level_w),
      .full      (full)
   );

   afifo_rd_ctrl u_rd_ctrl (
      .rd_clk    (rd_clk),
      .rst       (rst),
      .read_en   (read_en),
      .wr_gray   (wr_gray),
      .rd_gray   (rd_gray),
      .rd_addr   (rd_addr),
      .rd_accept (rd_accept),
      .level_r   (level_r),
      .empty     (empty)
   );

   afifo_asym_mem u_mem (
      .clk       (clk),
      .wr_accept (wr_accept),
      .wr_addr   (wr_addr),
      .data_in   (data_in),
      .rd_clk    (rd_clk),
      .rst       (rst),
      .rd_accept (rd_accept),
      .rd_addr   (rd_addr),
      .data_out  (data_out)
   );

endmodule

// File: testbench/afifo_checker.sv
`timescale 1ns/1ps

module afifo_checker (
   input logic                    clk,
   input logic                    rd_clk,
   input logic                    rst,
   input logic                    full,
   input afifo_ptr_pkg::w_ptr_t   level_w,
   input logic                    read_en,
   input logic                    empty,
   input afifo_ptr_pkg::r_ptr_t   level_r,
   input afifo_data_pkg::r_data_t data_out
);

   import afifo_ptr_pkg::*;

   // full is reached only by one write from a single free slot
   full_after_one_step: assert property (
      @(posedge clk) disable iff (rst)
      $rose(full) |-> ($past(level_w) == (w_ptr_t'('1) - 1'b1))
   ) else $error("full rose without level_w stepping up from one slot below");

   // empty is reached only by reading the last whole word
   empty_after_last_read: assert property (
      @(posedge rd_clk) disable iff (rst)
      $rose(empty) |-> ($past(level_r) == r_ptr_t'(1))
   ) else $error("empty rose without level_r stepping down from one word");

   // a dropped read keeps the last word on the output
   data_held_on_empty_read: assert property (
      @(posedge rd_clk) disable iff (rst)
      (read_en && empty) |=> $stable(data_out)
   ) else $error("data_out changed after a read while empty");

endmodule

bind afifo_asym_top afifo_checker u_checker (
   .clk      (clk),
   .rd_clk   (rd_clk),
   .rst      (rst),
   .full     (full),
   .level_w  (level_w),
   .read_en  (read_en),
   .empty    (empty),
   .level_r  (level_r),
   .data_out (data_out)
);

// File: testbench/afifo_tb.sv
`timescale 1ns/1ps

module afifo_tb;

   import afifo_data_pkg::*;
   import afifo_ptr_pkg::*;

   // cycles of the local clock before a wait gives up
   localparam int WAIT_TIMEOUT = 400;

   logic    clk;
   logic    rd_clk;
   logic    rst;
   logic    write_en;
   w_data_t data_in;
   logic    full;
   w_ptr_t  level_w;
   logic    read_en;
   r_data_t data_out;
   logic    empty;
   r_ptr_t  level_r;

   // words packed from random bytes, oldest first
   r_data_t expect_q[$];
   // random bytes not yet forming a whole word
   w_data_t partial_q[$];
   r_data_t last_word;
   integer  seed = 58;

   afifo_asym_top uut (
      .clk      (clk),
      .rd_clk   (rd_clk),
      .rst      (rst),
      .write_en (write_en),
      .data_in  (data_in),
      .full     (full),
      .level_w  (level_w),
      .read_en  (read_en),
      .data_out (data_out),
      .empty    (empty),
      .level_r  (level_r)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      rd_clk = 1'b0;
      forever #5 rd_clk = ~rd_clk;
   end

   task automatic stop_run();
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic write_byte(input w_data_t value);
      int cycles;
      cycles = 0;
      @(posedge clk);
      #1;
      while (full !== 1'b0 && cycles < WAIT_TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (full === 1'b0) else begin
         $display("timed out waiting for full to fall before a write");
         stop_run();
      end
      write_en = 1'b1;
      data_in  = value;
      @(posedge clk);
      #1;
      write_en = 1'b0;
   endtask

   // a write against a full fifo must leave the level alone
   task automatic write_ignored(input w_data_t value);
      @(posedge clk);
      #1;
      check_value("full", 32'(full), 32'h1);
      write_en = 1'b1;
      data_in  = value;
      @(posedge clk);
      #1;
      write_en = 1'b0;
      check_value("level_w", 32'(level_w), 32'hff);
      check_value("full", 32'(full), 32'h1);
   endtask

   task automatic read_word(output r_data_t word);
      int cycles;
      cycles = 0;
      @(posedge rd_clk);
      #1;
      while (empty !== 1'b0 && cycles < WAIT_TIMEOUT) begin
         @(posedge rd_clk);
         #1;
         cycles++;
      end
      assert (empty === 1'b0) else begin
         $display("timed out waiting for a readable word");
         stop_run();
      end
      read_en = 1'b1;
      // one cycle of read latency
      @(posedge rd_clk);
      #1;
      read_en = 1'b0;
      word = data_out;
   endtask

   task automatic read_on_empty();
      @(posedge rd_clk);
      #1;
      check_value("empty", 32'(empty), 32'h1);
      read_en = 1'b1;
      @(posedge rd_clk);
      #1;
      read_en = 1'b0;
      @(posedge rd_clk);
      #1;
      check_value("data_out", data_out, last_word);
      check_value("level_r", 32'(level_r), 32'h0);
   endtask

   task automatic fill_random(input int count);
      w_data_t value;
      int i;
      for (i = 0; i < count; i++) begin
         value = w_data_t'($random(seed));
         write_byte(value);
         partial_q.push_back(value);
         if (partial_q.size() == 4) begin
            // first byte written sits in the low lane
            expect_q.push_back({partial_q[3], partial_q[2], partial_q[1], partial_q[0]});
            partial_q.delete();
         end
      end
   endtask

   task automatic read_packed(input int count);
      r_data_t got;
      r_data_t exp;
      int i;
      for (i = 0; i < count; i++) begin
         assert (expect_q.size() > 0) else begin
            $display("a packed read was requested but no packed word is left");
            stop_run();
         end
         exp = expect_q.pop_front();
         read_word(got);
         check_value("data_out", got, exp);
         last_word = got;
      end
   endtask

   // polls empty or level_r in the read clock
   task automatic wait_rd_status(input bit on_level, input logic [31:0] target);
      int cycles;
      logic [31:0] seen;
      cycles = 0;
      @(posedge rd_clk);
      #1;
      seen = on_level ? 32'(level_r) : 32'(empty);
      while (seen !== target && cycles < WAIT_TIMEOUT) begin
         @(posedge rd_clk);
         #1;
         cycles++;
         seen = on_level ? 32'(level_r) : 32'(empty);
      end
      assert (seen === target) else begin
         $display("timed out waiting for %s to reach 0x%h, it stayed at 0x%h",
                  on_level ? "level_r" : "empty", target, seen);
         stop_run();
      end
   endtask

   // polls full or level_w in the write clock
   task automatic wait_wr_status(input bit on_level, input logic [31:0] target);
      int cycles;
      logic [31:0] seen;
      cycles = 0;
      @(posedge clk);
      #1;
      seen = on_level ? 32'(level_w) : 32'(full);
      while (seen !== target && cycles < WAIT_TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
         seen = on_level ? 32'(level_w) : 32'(full);
      end
      assert (seen === target) else begin
         $display("timed out waiting for %s to reach 0x%h, it stayed at 0x%h",
                  on_level ? "level_w" : "full", target, seen);
         stop_run();
      end
   endtask

   initial begin
      int fd;
      int line_no;
      int count;
      string line;
      logic [7:0] cmd;
      logic [31:0] arg;
      r_data_t got;
      write_en  = 1'b0;
      data_in   = '0;
      read_en   = 1'b0;
      rst       = 1'b1;
      last_word = '0;
      line_no   = 0;
      count     = 0;
      arg       = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      fd = $fopen("testbench/afifo_tests.txt", "r");
      assert (fd != 0) else begin
         $display("the test file testbench/afifo_tests.txt could not be opened");
         stop_run();
      end
      while ($fgets(line, fd) != 0) begin
         line_no++;
         if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
            continue;
         end
         // values are hex, counts are decimal
         void'($sscanf(line, "%c %h", cmd, arg));
         void'($sscanf(line, "%c %d", cmd, count));
         case (cmd)
            "W": write_byte(w_data_t'(arg));
            "X": write_ignored(w_data_t'(arg));
            "F": fill_random(count);
            "R": begin
               read_word(got);
               check_value("data_out", got, arg);
               last_word = got;
            end
            "Q": read_packed(count);
            "N": read_on_empty();
            "O": begin
               @(posedge rd_clk);
               #1;
               check_value("data_out", data_out, arg);
            end
            "E": wait_rd_status(1'b0, arg);
            "M": wait_rd_status(1'b1, arg);
            "U": wait_wr_status(1'b0, arg);
            "L": wait_wr_status(1'b1, arg);
            "H": repeat (count) @(posedge rd_clk);
            default: begin
               $display("unknown command '%c' on line %0d of the test file", cmd, line_no);
               stop_run();
            end
         endcase
      end
      $fclose(fd);
      $display("Verification passed");
      $finish;
   end

endmodule

// File: testbench/afifo_tests.txt
# command letter, then a hex value (W X R O E U L M) or a decimal count (F Q H)
# W/X write byte, F random bytes, R/O expected word, Q packed reads, N empty read
# idle state after reset
E 1
U 0
L 00
M 00
O 00000000
# three bytes leave the word incomplete
W 11
W 22
W 33
L 03
H 8
E 1
W 44
E 0
R 44332211
E 1
N
# fill until full, then drain
L 00
F 255
U 1
L ff
X 5a
M 3f
Q 63
E 1
N
F 1
Q 1
# interleaved traffic across pointer wrap
F 26
Q 5
F 30
Q 8
F 44
Q 10
F 40
Q 9
F 52
Q 12
F 36
Q 10
F 48
Q 10
F 44
Q 6
M 0a
Q 10
E 1
L 00

// File: filelist.f
+incdir+include
hw/afifo_data_pkg.sv
hw/afifo_ptr_pkg.sv
hw/afifo_gray_counter.sv
hw/afifo_wr_ctrl.sv
hw/afifo_rd_ctrl.sv
hw/afifo_asym_mem.sv
hw/afifo_asym_top.sv
testbench/afifo_checker.sv
testbench/afifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the afifo testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   --top-module afifo_tb \
   -f filelist.f \
   -o afifo_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/afifo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
fi

# the log decides the result
if grep -qx "Verification passed" "$LOG"; then
   echo "run passed"
   exit 0
else
   echo "run failed, see $LOG"
   exit 1
fi
